// File: rtl/wfe_config.svh
`ifndef WFE_CONFIG_SVH
`define WFE_CONFIG_SVH

// ==================================================
// sample stream and window
// ==================================================
`define WFE_DATA_WIDTH   11
`define WFE_WINDOW_LOG2  10                      // 1024 samples per window
`define WFE_CNT_WIDTH    (`WFE_WINDOW_LOG2 + 1)

// ==================================================
// arithmetic widths
// ==================================================
`define WFE_ACC_WIDTH    32
`define WFE_FEAT_WIDTH   16
`define WFE_DIV_WIDTH    24                      // also the divider latency in cycles
`define WFE_ZCR_SHIFT    6

`endif

// File: rtl/wfe_pkg.sv
`include "wfe_config.svh"
`default_nettype none

package wfe_pkg;

    // raw input sample, two's complement
    typedef logic signed [`WFE_DATA_WIDTH-1:0] sample_t;

    // window sums
    typedef logic signed [`WFE_ACC_WIDTH-1:0]  acc_t;

    // published features
    typedef logic        [`WFE_FEAT_WIDTH-1:0] feature_t;
    typedef logic signed [`WFE_FEAT_WIDTH-1:0] sfeature_t;

    // divider dividend and raw quotient
    typedef logic        [`WFE_DIV_WIDTH-1:0]  div_t;

endpackage

`default_nettype wire

// File: rtl/window_ctrl.sv
`include "wfe_config.svh"
`default_nettype none

module window_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic signal_valid,
    input  logic done,
    output logic sample_take,
    output logic window_last,
    output logic busy
);

    localparam logic [`WFE_CNT_WIDTH-1:0] LAST_IDX = (1 << `WFE_WINDOW_LOG2) - 1;

    logic [`WFE_CNT_WIDTH-1:0] sample_cnt;   // samples taken in the open window

    // samples offered during the compute phase are simply dropped
    assign sample_take = signal_valid && !busy;
    assign window_last = sample_take && (sample_cnt == LAST_IDX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt <= '0;
        end else if (sample_take) begin
            if (window_last) begin
                sample_cnt <= '0;
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    // busy covers the whole compute phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (window_last) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // the sequencer may only finish a window that has been closed here
    a_done_only_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> busy);

endmodule

`default_nettype wire

// File: rtl/zero_cross_counter.sv
`include "wfe_config.svh"
`default_nettype none

module zero_cross_counter
    import wfe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  sample_t  signal_in,
    input  logic     sample_take,
    input  logic     window_last,
    output feature_t crossings
);

    logic                      prev_sign;   // sign bit of the last accepted sample
    logic                      have_prev;   // low until a window has its first sample
    logic                      cross_now;
    logic [`WFE_CNT_WIDTH-1:0] cross_cnt;
    logic [`WFE_CNT_WIDTH-1:0] cross_total;

    // zero counts as non-negative, so only the sign bit matters
    assign cross_now   = have_prev && (prev_sign != signal_in[`WFE_DATA_WIDTH-1]);
    assign cross_total = cross_cnt + cross_now;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_sign <= 1'b0;
            have_prev <= 1'b0;
            cross_cnt <= '0;
            crossings <= '0;
        end else if (sample_take) begin
            if (window_last) begin
                // scaled count, top bits drop off
                crossings <= feature_t'(cross_total) << `WFE_ZCR_SHIFT;
                cross_cnt <= '0;
                have_prev <= 1'b0;            // next window starts with no pair
            end else begin
                cross_cnt <= cross_total;
                have_prev <= 1'b1;
            end
            prev_sign <= signal_in[`WFE_DATA_WIDTH-1];
        end
    end

endmodule

`default_nettype wire

// File: rtl/amplitude_stats.sv
`include "wfe_config.svh"
`default_nettype none

module amplitude_stats
    import wfe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t signal_in,
    input  logic    sample_take,
    input  logic    window_last,
    output sample_t peak_max,
    output sample_t peak_min,
    output acc_t    sum_abs,
    output acc_t    sum_square,
    output acc_t    sum_signal,
    output logic    stats_ready
);

    localparam int W = `WFE_DATA_WIDTH;

    localparam sample_t MOST_POS = {1'b0, {(W-1){1'b1}}};
    localparam sample_t MOST_NEG = {1'b1, {(W-1){1'b0}}};

    sample_t                run_max, run_min;
    acc_t                   acc_abs, acc_sq, acc_sum;
    logic signed [W:0]      wide_in;       // one extra bit so -1024 negates cleanly
    logic        [W:0]      mag;
    logic signed [2*W-1:0]  square;
    sample_t                max_next, min_next;
    acc_t                   abs_next, sq_next, sum_next;

    // ==================================================
    // running values including the current sample
    // ==================================================
    always_comb begin
        wide_in  = signal_in;
        mag      = wide_in[W] ? -wide_in : wide_in;
        square   = signal_in * signal_in;
        max_next = (signal_in > run_max) ? signal_in : run_max;
        min_next = (signal_in < run_min) ? signal_in : run_min;
        abs_next = acc_abs + acc_t'(mag);
        sq_next  = acc_sq + square;
        sum_next = acc_sum + signal_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_max     <= MOST_NEG;
            run_min     <= MOST_POS;
            acc_abs     <= '0;
            acc_sq      <= '0;
            acc_sum     <= '0;
            stats_ready <= 1'b0;
        end else begin
            stats_ready <= sample_take && window_last;
            if (sample_take && window_last) begin
                // reseed for the next window
                run_max <= MOST_NEG;
                run_min <= MOST_POS;
                acc_abs <= '0;
                acc_sq  <= '0;
                acc_sum <= '0;
            end else if (sample_take) begin
                run_max <= max_next;
                run_min <= min_next;
                acc_abs <= abs_next;
                acc_sq  <= sq_next;
                acc_sum <= sum_next;
            end
        end
    end

    // ==================================================
    // window totals, stable until the next window closes
    // ==================================================
    always_ff @(posedge clk) begin
        if (sample_take && window_last) begin
            peak_max   <= max_next;
            peak_min   <= min_next;
            sum_abs    <= abs_next;
            sum_square <= sq_next;
            sum_signal <= sum_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ratio_divider.sv
`include "wfe_config.svh"
`default_nettype none

module ratio_divider
    import wfe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     div_start,
    input  div_t     dividend,
    input  feature_t divisor,
    output feature_t quotient,
    output logic     div_done
);

    localparam int DW = `WFE_DIV_WIDTH;
    localparam int FW = `WFE_FEAT_WIDTH;
    localparam int CW = $clog2(DW);

    logic          running;
    logic [CW-1:0] steps_left;
    div_t          quo_q, quo_src, quo_next;     // dividend shifts out, quotient in
    feature_t      rem_q, rem_src, rem_next;
    feature_t      dsr_q, dsr_src;
    logic [FW:0]   shifted;
    logic [FW+1:0] trial;

    // ==================================================
    // one restoring step per cycle
    // ==================================================
    always_comb begin
        // the first step runs on the inputs in the start cycle
        if (running) begin
            quo_src = quo_q;
            rem_src = rem_q;
            dsr_src = dsr_q;
        end else begin
            quo_src = dividend;
            rem_src = '0;
            dsr_src = divisor;
        end
        shifted = {rem_src, quo_src[DW-1]};
        trial   = {1'b0, shifted} - {2'b00, dsr_src};
        if (trial[FW+1]) begin
            rem_next = shifted[FW-1:0];          // went negative, restore
        end else begin
            rem_next = trial[FW-1:0];
        end
        quo_next = {quo_src[DW-2:0], ~trial[FW+1]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running    <= 1'b0;
            steps_left <= '0;
            div_done   <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                running    <= 1'b1;
                steps_left <= CW'(DW - 1);
            end else if (running) begin
                steps_left <= steps_left - 1'b1;
                if (steps_left == CW'(1)) begin
                    running  <= 1'b0;
                    div_done <= 1'b1;            // last quotient bit lands now
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start || running) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
        end
        if (div_start) begin
            dsr_q <= divisor;
        end
    end

    // clip to full scale
    assign quotient = (|quo_q[DW-1:FW]) ? '1 : quo_q[FW-1:0];

    a_divisor_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        div_start |-> (divisor != '0));

    a_single_division: assert property (@(posedge clk) disable iff (!rst_n)
        div_start |-> !running);

endmodule

`default_nettype wire

// File: rtl/feature_sequencer.sv
`include "wfe_config.svh"
`default_nettype none

module feature_sequencer
    import wfe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stats_ready,
    input  sample_t   peak_max,
    input  sample_t   peak_min,
    input  acc_t      sum_abs,
    input  acc_t      sum_square,
    input  acc_t      sum_signal,
    input  feature_t  crossings,
    input  feature_t  quotient,
    input  logic      div_done,
    output logic      div_start,
    output div_t      dividend,
    output feature_t  divisor,
    output logic      done,
    output feature_t  zcr,
    output feature_t  crest_factor,
    output feature_t  form_factor,
    output feature_t  mean_square,
    output sfeature_t mean_value,
    output logic      features_valid
);

    localparam int FW = `WFE_FEAT_WIDTH;

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_PREPARE = 3'd1;
    localparam logic [2:0] ST_CREST   = 3'd2;
    localparam logic [2:0] ST_FORM    = 3'd3;
    localparam logic [2:0] ST_PUBLISH = 3'd4;

    localparam feature_t CREST_DIV0 = 16'hFFFF;
    localparam feature_t FORM_DIV0  = 16'h0100;   // 1.0 in Q8.8

    logic [2:0] state;
    acc_t       ms_full, abs_full, sum_full;
    feature_t   p2p_q, ms_q, avg_q;
    sfeature_t  mean_q;
    feature_t   crest_q, form_q;
    logic       crest_go, crest_end, form_go, form_skip;

    // window means, divide by window length
    always_comb begin
        ms_full  = sum_square >> `WFE_WINDOW_LOG2;
        abs_full = sum_abs >> `WFE_WINDOW_LOG2;
        sum_full = sum_signal >>> `WFE_WINDOW_LOG2;
    end

    // ==================================================
    // divider launch
    // ==================================================
    assign crest_go  = (state == ST_PREPARE) && (ms_q != '0);
    assign crest_end = ((state == ST_PREPARE) && (ms_q == '0)) ||
                       ((state == ST_CREST) && div_done);
    assign form_go   = crest_end && (avg_q != '0);
    assign form_skip = crest_end && (avg_q == '0);

    assign div_start = crest_go || form_go;
    assign dividend  = crest_go ? div_t'({p2p_q, 8'h00}) : div_t'({ms_q, 8'h00});
    assign divisor   = crest_go ? ms_q : avg_q;

    // operands and ratios, only read inside the compute phase
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && stats_ready) begin
            p2p_q  <= feature_t'(sfeature_t'(peak_max) - sfeature_t'(peak_min));
            ms_q   <= ms_full[FW-1:0];
            avg_q  <= abs_full[FW-1:0];
            mean_q <= sum_full[FW-1:0];
        end
        if ((state == ST_PREPARE) && (ms_q == '0)) begin
            crest_q <= CREST_DIV0;
        end else if ((state == ST_CREST) && div_done) begin
            crest_q <= quotient;
        end
        if (form_skip) begin
            form_q <= FORM_DIV0;
        end else if ((state == ST_FORM) && div_done) begin
            form_q <= quotient;
        end
    end

    // ==================================================
    // FSM and output registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            done           <= 1'b0;
            features_valid <= 1'b0;
            zcr            <= '0;
            crest_factor   <= '0;
            form_factor    <= '0;
            mean_square    <= '0;
            mean_value     <= '0;
        end else begin
            done           <= 1'b0;
            features_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (stats_ready) begin
                        state <= ST_PREPARE;
                    end
                end
                ST_PREPARE: begin
                    if (crest_go) begin
                        state <= ST_CREST;
                    end else begin
                        state <= form_go ? ST_FORM : ST_PUBLISH;
                    end
                end
                ST_CREST: begin
                    if (div_done) begin
                        state <= form_go ? ST_FORM : ST_PUBLISH;
                    end
                end
                ST_FORM: begin
                    if (div_done) begin
                        state <= ST_PUBLISH;
                    end
                end
                ST_PUBLISH: begin
                    zcr            <= crossings;
                    crest_factor   <= crest_q;
                    form_factor    <= form_q;
                    mean_square    <= ms_q;
                    mean_value     <= mean_q;
                    features_valid <= 1'b1;
                    done           <= 1'b1;  // releases busy
                    state          <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // a new window can only close once the previous one is published
    a_ready_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        stats_ready |-> (state == ST_IDLE));

endmodule

`default_nettype wire

// File: rtl/wfe_top.sv
`default_nettype none

module wfe_top
    import wfe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  sample_t   signal_in,
    input  logic      signal_valid,
    output feature_t  zcr,
    output feature_t  crest_factor,
    output feature_t  form_factor,
    output sfeature_t mean_value,
    output feature_t  mean_square,
    output logic      features_valid,
    output logic      busy
);

    logic     sample_take;
    logic     window_last;
    logic     done;
    feature_t crossings;

    // window totals
    sample_t  peak_max, peak_min;
    acc_t     sum_abs, sum_square, sum_signal;
    logic     stats_ready;

    // shared divider
    logic     div_start, div_done;
    div_t     dividend;
    feature_t divisor, quotient;

    window_ctrl window_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .signal_valid (signal_valid),
        .done         (done),
        .sample_take  (sample_take),
        .window_last  (window_last),
        .busy         (busy)
    );

    zero_cross_counter zero_cross_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .signal_in   (signal_in),
        .sample_take (sample_take),
        .window_last (window_last),
        .crossings   (crossings)
    );

    amplitude_stats amplitude_stats_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .signal_in   (signal_in),
        .sample_take (sample_take),
        .window_last (window_last),
        .peak_max    (peak_max),
        .peak_min    (peak_min),
        .sum_abs     (sum_abs),
        .sum_square  (sum_square),
        .sum_signal  (sum_signal),
        .stats_ready (stats_ready)
    );

    ratio_divider ratio_divider_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .div_start (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .div_done  (div_done)
    );

    feature_sequencer feature_sequencer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .stats_ready    (stats_ready),
        .peak_max       (peak_max),
        .peak_min       (peak_min),
        .sum_abs        (sum_abs),
        .sum_square     (sum_square),
        .sum_signal     (sum_signal),
        .crossings      (crossings),
        .quotient       (quotient),
        .div_done       (div_done),
        .div_start      (div_start),
        .dividend       (dividend),
        .divisor        (divisor),
        .done           (done),
        .zcr            (zcr),
        .crest_factor   (crest_factor),
        .form_factor    (form_factor),
        .mean_square    (mean_square),
        .mean_value     (mean_value),
        .features_valid (features_valid)
    );

endmodule

`default_nettype wire

// File: bench/wfe_tb.sv
`include "wfe_config.svh"
`default_nettype none

module wfe_tb
    import wfe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WIN           = 1 << `WFE_WINDOW_LOG2;
    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int RUN_WINDOWS   = 6;    // gapped window counts twice
    localparam int TIMEOUT_NS    = RUN_WINDOWS * (WIN + 200) * CLK_PERIOD + 2000;
    localparam int FV_WAIT_LIMIT = 200;  // compute phase is far shorter
    localparam logic [31:0] LCG_SEED = 32'h6657_fe96;

    logic      clk;
    logic      rst_n;
    logic      signal_valid;
    sample_t   signal_in;
    feature_t  zcr;
    feature_t  crest_factor;
    feature_t  form_factor;
    feature_t  mean_square;
    sfeature_t mean_value;
    logic      features_valid;
    logic      busy;

    int          error_count;
    logic [31:0] lcg_state;
    int          win_q[$];              // samples the DUT should accept for one window
    feature_t    exp_zcr, exp_crest, exp_form, exp_ms, exp_mean;

    wfe_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .signal_in      (signal_in),
        .signal_valid   (signal_valid),
        .zcr            (zcr),
        .crest_factor   (crest_factor),
        .form_factor    (form_factor),
        .mean_value     (mean_value),
        .mean_square    (mean_square),
        .features_valid (features_valid),
        .busy           (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_sample();
        logic [31:0] r;
        r = lcg_next();
        return int'($signed(r[26:16]));   // upper bits are the better ones
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    // reference features of win_q
    task automatic compute_expected();
        int     crossings, peak_hi, peak_lo, p2p, s;
        longint sum_abs, sum_sq, sum_all, ms, avg, ratio;
        crossings = 0;
        peak_hi   = 0;
        peak_lo   = 0;
        sum_abs   = 0;
        sum_sq    = 0;
        sum_all   = 0;
        foreach (win_q[i]) begin
            s = win_q[i];
            if (i > 0 && ((s < 0) != (win_q[i-1] < 0))) begin
                crossings++;
            end
            if (i == 0 || s > peak_hi) peak_hi = s;
            if (i == 0 || s < peak_lo) peak_lo = s;
            sum_abs += (s < 0) ? -s : s;
            sum_sq  += s * s;
            sum_all += s;
        end
        p2p      = peak_hi - peak_lo;
        ms       = (sum_sq >> `WFE_WINDOW_LOG2) & 64'hFFFF;
        avg      = (sum_abs >> `WFE_WINDOW_LOG2) & 64'hFFFF;
        exp_zcr  = feature_t'(crossings << `WFE_ZCR_SHIFT);
        exp_ms   = feature_t'(ms);
        exp_mean = feature_t'(sum_all >>> `WFE_WINDOW_LOG2);
        if (ms == 0) begin
            exp_crest = 16'hFFFF;
        end else begin
            ratio     = (longint'(p2p) * 256) / ms;
            exp_crest = (ratio > 65535) ? 16'hFFFF : feature_t'(ratio);
        end
        if (avg == 0) begin
            exp_form = 16'h0100;                 // 1.0 in Q8.8
        end else begin
            ratio    = (ms * 256) / avg;
            exp_form = (ratio > 65535) ? 16'hFFFF : feature_t'(ratio);
        end
    endtask

    task automatic drive_window(input bit with_gaps);
        logic [31:0] r;
        foreach (win_q[i]) begin
            if (with_gaps) begin
                r = lcg_next();
                if (r[5:4] == 2'b00) begin       // idle cycle, about one in four
                    @(negedge clk);
                    signal_valid = 1'b0;
                end
            end
            @(negedge clk);
            if (busy) begin
                error_count++;
                $display("ERROR: busy was high before sample %0d of the window", i);
            end
            signal_in    = sample_t'(win_q[i]);
            signal_valid = 1'b1;
        end
    endtask

    // wait for the features, optionally offering junk while busy
    task automatic collect_features(input bit flood_busy);
        int waited;
        int dropped;
        bit seen;
        waited  = 0;
        dropped = 0;
        seen    = 1'b0;
        while (!seen && waited < FV_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            seen = features_valid;
            if (flood_busy && busy) begin
                signal_in    = sample_t'(-1024);
                signal_valid = 1'b1;
                dropped++;
            end else begin
                signal_valid = 1'b0;
            end
        end
        if (!seen) begin
            error_count++;
            $display("ERROR: features_valid did not arrive within %0d cycles", FV_WAIT_LIMIT);
        end else begin
            check_value("zcr", exp_zcr, zcr);
            check_value("crest_factor", exp_crest, crest_factor);
            check_value("form_factor", exp_form, form_factor);
            check_value("mean_square", exp_ms, mean_square);
            check_value("mean_value", exp_mean, mean_value);
        end
        if (flood_busy && dropped == 0) begin
            error_count++;
            $display("ERROR: no samples could be offered while busy was high");
        end
        @(negedge clk);
        signal_valid = 1'b0;
        check_value("features_valid", 16'h0, 16'(features_valid));   // one-cycle pulse
        check_value("busy", 16'h0, 16'(busy));
    endtask

    task automatic run_window(input bit with_gaps, input bit flood_busy);
        compute_expected();
        drive_window(with_gaps);
        collect_features(flood_busy);
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_after_reset();
        $display("test 1: outputs after reset");
        @(negedge clk);
        check_value("features_valid", 16'h0, 16'(features_valid));
        check_value("busy", 16'h0, 16'(busy));
        check_value("zcr", 16'h0, zcr);
        check_value("crest_factor", 16'h0, crest_factor);
        check_value("form_factor", 16'h0, form_factor);
        check_value("mean_square", 16'h0, mean_square);
        check_value("mean_value", 16'h0, mean_value);
    endtask

    task automatic test_constant();
        $display("test 2: constant window of 100");
        win_q.delete();
        repeat (WIN) win_q.push_back(100);
        run_window(1'b0, 1'b0);
    endtask

    task automatic test_square();
        $display("test 3: alternating +/-200");
        win_q.delete();
        for (int i = 0; i < WIN; i++) begin
            win_q.push_back((i % 2 == 0) ? 200 : -200);
        end
        run_window(1'b0, 1'b0);
    endtask

    task automatic test_zero();
        $display("test 4: all-zero window");
        win_q.delete();
        repeat (WIN) win_q.push_back(0);
        run_window(1'b0, 1'b0);
    endtask

    task automatic test_busy_and_random();
        $display("test 5: samples while busy, then random window with gaps");
        win_q.delete();
        repeat (WIN) win_q.push_back(random_sample());
        run_window(1'b0, 1'b1);
        // any -1024 that slipped in would land in this window
        win_q.delete();
        repeat (WIN) win_q.push_back(random_sample());
        run_window(1'b1, 1'b0);
    endtask

    // ==================================================
    // main sequence and watchdog
    // ==================================================
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        signal_valid = 1'b0;
        signal_in    = '0;
        error_count  = 0;
        lcg_state    = LCG_SEED;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_after_reset();
        test_constant();
        test_square();
        test_zero();
        test_busy_and_random();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: timeout, the run did not complete within %0d ns", TIMEOUT_NS);
        $display("errors: %0d", error_count + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: wfe.f
+incdir+rtl
rtl/wfe_pkg.sv
rtl/window_ctrl.sv
rtl/zero_cross_counter.sv
rtl/amplitude_stats.sv
rtl/ratio_divider.sv
rtl/feature_sequencer.sv
rtl/wfe_top.sv
bench/wfe_tb.sv
